/* sim.f */
csr_pkg.sv
csr_decode.sv
irq_cell.sv
trap_ctrl.sv
csr_unit.sv
tb_csr_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_csr_unit -o tb_csr_unit

./obj_dir/tb_csr_unit 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure, see sim.log"
    exit 1
fi
echo "simulation finished without failure"

/* tb_csr_unit.sv */
`timescale 1ns/10ps

module tb_csr_unit;
    import csr_pkg::*;

    localparam logic [31:0] INSTR_NOP    = 32'h0000_0013;
    localparam logic [31:0] INSTR_ECALL  = 32'h0000_0073;
    localparam logic [31:0] INSTR_MRET   = 32'h3020_0073;
    localparam logic [63:0] ALIGN        = 64'hFFFF_FFFF_FFFF_FFFC;
    localparam int          RESET_CYCLES = 5;
    // csrrw, csrrs, csrrc, then the immediate forms
    localparam logic [2:0]  OP_LIST [6]  = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    localparam logic [11:0] TARGETS [3]  = '{CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};

    typedef struct packed {
        logic [31:0] instr;
        logic [63:0] rs1;
        logic [63:0] pc;
        logic [63:0] irq_pc;
        logic        stall_n;
        logic [2:0]  irq;
        logic [63:0] exp_rdata;
        logic        exp_trap;
        logic [63:0] exp_mtvec;
        logic [63:0] exp_mepc;
        logic [2:0]  test;
    } row_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] instr;
    logic [63:0] rs1_data;
    logic [63:0] pc;
    logic [63:0] irq_pc;
    logic        stall_n;
    logic [2:0]  irq;
    logic [63:0] csr_rdata;
    logic [63:0] mtvec;
    logic [63:0] mepc;
    logic        trap_taken;

    row_t        rows [$];
    string       test_names [6] = '{"reset values", "write ops", "stall", "ecall",
                                    "interrupts", "mret"};
    logic [2:0]  cur_test = 3'd0;
    logic [63:0] rng_state = 64'd69;
    int          test_errs = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    // model of the CSR state, advanced while the table is built
    logic [63:0] m_mstatus = MSTATUS_RESET;
    logic [63:0] m_mtvec = 64'd0;
    logic [63:0] m_mepc = 64'd0;
    logic [63:0] m_mcause = 64'd0;
    logic [2:0]  m_mie = 3'b000;
    logic [2:0]  m_mip = 3'b000;

    csr_unit csr_unit_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_i      (instr),
        .rs1_data_i   (rs1_data),
        .pc_i         (pc),
        .irq_pc_i     (irq_pc),
        .stall_n_i    (stall_n),
        .irq_i        (irq),
        .csr_rdata_o  (csr_rdata),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .trap_taken_o (trap_taken)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [63:0] next_random(input logic [63:0] s);
        logic [63:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return x;
    endfunction

    // sw, timer, ext sit at mip/mie bits 3, 7, 11
    function automatic logic [63:0] spread_irq(input logic [2:0] bits);
        logic [63:0] word;
        word     = 64'd0;
        word[3]  = bits[0];
        word[7]  = bits[1];
        word[11] = bits[2];
        return word;
    endfunction

    function automatic logic [2:0] gather_irq(input logic [63:0] word);
        return {word[11], word[7], word[3]};
    endfunction

    function automatic logic [63:0] csr_write_value(input logic [1:0] kind,
                                                    input logic [63:0] old_val,
                                                    input logic [63:0] opnd);
        case (kind)
            2'b01:   return opnd;
            2'b10:   return old_val | opnd;
            2'b11:   return old_val & ~opnd;
            default: return old_val;
        endcase
    endfunction

    function automatic logic [63:0] model_read(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS: return m_mstatus;
            CSR_MTVEC:   return m_mtvec;
            CSR_MEPC:    return m_mepc;
            CSR_MCAUSE:  return m_mcause;
            CSR_MIE:     return spread_irq(m_mie);
            CSR_MIP:     return spread_irq(m_mip);
            default:     return 64'd0;
        endcase
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                              input logic [4:0] src);
        return {addr, src, f3, 5'd1, 7'b1110011};
    endfunction

    task automatic add_row(input logic [31:0] instr_v, input logic [63:0] rs1_v,
                           input logic [63:0] pc_v, input logic [63:0] irq_pc_v,
                           input logic stall_v, input logic [2:0] irq_v);
        row_t        r;
        logic [2:0]  f3;
        logic [11:0] addr;
        logic        is_csr;
        logic        is_ecall;
        logic        take_irq;
        logic        wr;
        logic [63:0] opnd;
        logic [2:0]  hit;
        logic [2:0]  mip_nxt;
        logic [5:0]  code;
        int          j;
        f3       = instr_v[14:12];
        addr     = instr_v[31:20];
        is_csr   = (instr_v[6:0] == 7'b1110011) && (f3[1:0] != 2'b00);
        is_ecall = (instr_v == INSTR_ECALL);
        opnd     = f3[2] ? {59'd0, instr_v[19:15]} : rs1_v;
        hit      = m_mie & m_mip;
        take_irq = m_mstatus[3] && (hit != 3'b000);
        wr       = is_csr && stall_v && !take_irq && !is_ecall;

        r.instr     = instr_v;
        r.rs1       = rs1_v;
        r.pc        = pc_v;
        r.irq_pc    = irq_pc_v;
        r.stall_n   = stall_v;
        r.irq       = irq_v;
        r.exp_rdata = is_csr ? model_read(addr) : 64'd0;
        r.exp_trap  = take_irq || is_ecall;
        r.test      = cur_test;

        // pending bits follow the lines even under stall
        mip_nxt = m_mip;
        for (j = 0; j < 3; j++) begin
            if (irq_v[j] && m_mie[j] && m_mstatus[3]) begin
                mip_nxt[j] = 1'b1;
            end else if (!irq_v[j]) begin
                mip_nxt[j] = 1'b0;
            end
        end
        if (wr && addr == CSR_MIP) begin
            mip_nxt = gather_irq(csr_write_value(f3[1:0], spread_irq(m_mip), opnd));
        end
        if (wr && addr == CSR_MIE) begin
            m_mie = gather_irq(csr_write_value(f3[1:0], spread_irq(m_mie), opnd));
        end

        if (stall_v) begin
            if (take_irq || is_ecall) begin
                m_mstatus[7] = m_mstatus[3];
                m_mstatus[3] = 1'b0;
            end else if (instr_v == INSTR_MRET) begin
                m_mstatus[3] = m_mstatus[7];
                m_mstatus[7] = 1'b1;
            end
            if (take_irq) begin
                // external over software over timer
                code     = hit[2] ? 6'd11 : (hit[0] ? 6'd3 : 6'd7);
                m_mepc   = irq_pc_v & ALIGN;
                m_mcause = {1'b1, 57'd0, code};
            end else if (is_ecall) begin
                m_mepc   = pc_v & ALIGN;
                m_mcause = 64'd11;
            end
            if (wr) begin
                case (addr)
                    CSR_MSTATUS: m_mstatus = csr_write_value(f3[1:0], m_mstatus, opnd);
                    CSR_MTVEC:   m_mtvec = csr_write_value(f3[1:0], m_mtvec, opnd) & ALIGN;
                    CSR_MEPC:    m_mepc = csr_write_value(f3[1:0], m_mepc, opnd) & ALIGN;
                    CSR_MCAUSE:  m_mcause = csr_write_value(f3[1:0], m_mcause, opnd);
                    default:     ;
                endcase
            end
        end
        m_mip = mip_nxt;

        r.exp_mtvec = m_mtvec;
        r.exp_mepc  = m_mepc;
        rows.push_back(r);
    endtask

    task automatic add_instr(input logic [31:0] instr_v, input logic [2:0] irq_v,
                             input logic [63:0] irq_pc_v);
        add_row(instr_v, 64'd0, 64'h1000, irq_pc_v, 1'b1, irq_v);
    endtask

    task automatic add_read(input logic [11:0] addr, input logic [2:0] irq_v);
        add_instr(csr_instr(3'b110, addr, 5'd0), irq_v, 64'h2000);
    endtask

    task automatic build_table();
        int t;
        int k;
        cur_test = 3'd0;
        add_read(CSR_MSTATUS, 3'b000);
        add_read(CSR_MIE, 3'b000);
        add_read(CSR_MTVEC, 3'b000);
        add_read(CSR_MEPC, 3'b000);
        add_read(CSR_MCAUSE, 3'b000);
        add_read(CSR_MIP, 3'b000);

        cur_test = 3'd1;
        for (t = 0; t < 3; t++) begin
            for (k = 0; k < 6; k++) begin
                rng_state = next_random(rng_state);
                add_row(csr_instr(OP_LIST[k], TARGETS[t], rng_state[4:0]), rng_state,
                        64'h1000, 64'h2000, 1'b1, 3'b000);
            end
            add_read(TARGETS[t], 3'b000);
        end

        cur_test = 3'd2;
        rng_state = next_random(rng_state);
        add_row(csr_instr(3'b001, CSR_MTVEC, 5'd6), rng_state, 64'h1000, 64'h2000,
                1'b0, 3'b000);
        add_row(csr_instr(3'b110, CSR_MTVEC, 5'd0), 64'd0, 64'h1000, 64'h2000, 1'b0, 3'b000);
        add_row(INSTR_ECALL, 64'd0, 64'h8000_0040, 64'h2000, 1'b0, 3'b000);
        add_read(CSR_MEPC, 3'b000);
        add_read(CSR_MSTATUS, 3'b000);

        cur_test = 3'd3;
        add_instr(csr_instr(3'b110, CSR_MSTATUS, 5'd8), 3'b000, 64'h2000);
        add_row(INSTR_ECALL, 64'd0, 64'h8000_0104, 64'h2000, 1'b1, 3'b000);
        add_read(CSR_MEPC, 3'b000);
        add_read(CSR_MCAUSE, 3'b000);
        add_read(CSR_MSTATUS, 3'b000);

        // all three lines at once, ext wins
        cur_test = 3'd4;
        add_row(csr_instr(3'b010, CSR_MIE, 5'd9), 64'h888, 64'h1000, 64'h2000, 1'b1, 3'b000);
        add_instr(csr_instr(3'b110, CSR_MSTATUS, 5'd8), 3'b000, 64'h2000);
        add_instr(INSTR_NOP, 3'b111, 64'h2000);
        add_instr(csr_instr(3'b110, CSR_MIP, 5'd0), 3'b111, 64'h8000_1236);
        add_read(CSR_MCAUSE, 3'b111);
        add_instr(INSTR_NOP, 3'b110, 64'h2000);
        add_read(CSR_MIP, 3'b110);
        add_read(CSR_MSTATUS, 3'b110);

        // mret reopens the window, then timer alone, then sw over timer
        cur_test = 3'd5;
        add_instr(INSTR_MRET, 3'b110, 64'h2000);
        add_instr(csr_instr(3'b110, CSR_MSTATUS, 5'd0), 3'b110, 64'h8000_2000);
        add_instr(INSTR_NOP, 3'b010, 64'h2000);
        add_read(CSR_MEPC, 3'b010);
        add_instr(INSTR_MRET, 3'b010, 64'h2000);
        add_instr(INSTR_NOP, 3'b010, 64'h8000_3008);
        add_read(CSR_MCAUSE, 3'b010);
        add_instr(csr_instr(3'b110, CSR_MIP, 5'd8), 3'b011, 64'h2000);
        add_instr(INSTR_MRET, 3'b011, 64'h2000);
        add_instr(INSTR_NOP, 3'b011, 64'h8000_400C);
        add_read(CSR_MCAUSE, 3'b011);
        add_instr(INSTR_NOP, 3'b000, 64'h2000);
        add_read(CSR_MIP, 3'b000);
        // mret with MPIE cleared leaves MIE off and sets MPIE
        add_row(csr_instr(3'b011, CSR_MSTATUS, 5'd10), 64'h80, 64'h1000, 64'h2000,
                1'b1, 3'b000);
        add_instr(INSTR_MRET, 3'b000, 64'h2000);
        add_read(CSR_MSTATUS, 3'b000);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("MISMATCH time %0t %s expected 0x%h actual 0x%h", $time, name, exp_v, act_v);
        test_errs = test_errs + 1;
    endtask

    task automatic check_after_edge(input row_t r);
        if (mtvec !== r.exp_mtvec) begin
            report_mismatch("mtvec_o", r.exp_mtvec, mtvec);
        end
        if (mepc !== r.exp_mepc) begin
            report_mismatch("mepc_o", r.exp_mepc, mepc);
        end
    endtask

    task automatic report_test(input logic [2:0] t);
        if (test_errs == 0) begin
            tests_passed = tests_passed + 1;
            $display("test %0d %s: pass", t, test_names[t]);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %0d %s: fail with %0d mismatches", t, test_names[t], test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int idx;
        rst_n    <= 1'b0;
        instr    <= INSTR_NOP;
        rs1_data <= 64'd0;
        pc       <= 64'd0;
        irq_pc   <= 64'd0;
        stall_n  <= 1'b1;
        irq      <= 3'b000;
        build_table();
        cycle_limit = rows.size() + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        for (idx = 0; idx < rows.size(); idx++) begin
            @(posedge clk);
            instr    <= rows[idx].instr;
            rs1_data <= rows[idx].rs1;
            pc       <= rows[idx].pc;
            irq_pc   <= rows[idx].irq_pc;
            stall_n  <= rows[idx].stall_n;
            irq      <= rows[idx].irq;
            @(negedge clk);
            if (idx > 0) begin
                check_after_edge(rows[idx-1]);
                if (rows[idx].test != rows[idx-1].test) begin
                    report_test(rows[idx-1].test);
                end
            end
            if (csr_rdata !== rows[idx].exp_rdata) begin
                report_mismatch("csr_rdata_o", rows[idx].exp_rdata, csr_rdata);
            end
            if (trap_taken !== rows[idx].exp_trap) begin
                report_mismatch("trap_taken_o", {63'd0, rows[idx].exp_trap}, {63'd0, trap_taken});
            end
        end

        @(posedge clk);
        instr   <= INSTR_NOP;
        irq     <= 3'b000;
        stall_n <= 1'b1;
        @(negedge clk);
        check_after_edge(rows[rows.size()-1]);
        report_test(rows[rows.size()-1].test);

        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* csr_unit.sv */
`timescale 1ns/10ps

module csr_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [31:0]                   instr_i,
    input  logic [csr_pkg::XLEN-1:0]      rs1_data_i,
    input  logic [csr_pkg::XLEN-1:0]      pc_i,
    input  logic [csr_pkg::XLEN-1:0]      irq_pc_i,
    input  logic                          stall_n_i,
    input  logic [csr_pkg::NUM_IRQ-1:0]   irq_i,
    output logic [csr_pkg::XLEN-1:0]      csr_rdata_o,
    output logic [csr_pkg::XLEN-1:0]      mtvec_o,
    output logic [csr_pkg::XLEN-1:0]      mepc_o,
    output logic                          trap_taken_o
);
    import csr_pkg::*;

    csr_op_e            csr_op;
    logic               sel_mstatus;
    logic               sel_mie;
    logic               sel_mtvec;
    logic               sel_mepc;
    logic               sel_mcause;
    logic               sel_mip;
    logic               is_ecall;
    logic               is_mret;
    logic [XLEN-1:0]    wr_operand;
    logic [NUM_IRQ-1:0] irq_en;
    logic [NUM_IRQ-1:0] irq_pend;
    logic               mstatus_mie;

    csr_decode u_csr_decode (
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .csr_op_o      (csr_op),
        .sel_mstatus_o (sel_mstatus),
        .sel_mie_o     (sel_mie),
        .sel_mtvec_o   (sel_mtvec),
        .sel_mepc_o    (sel_mepc),
        .sel_mcause_o  (sel_mcause),
        .sel_mip_o     (sel_mip),
        .is_ecall_o    (is_ecall),
        .is_mret_o     (is_mret),
        .wr_operand_o  (wr_operand)
    );

    // one cell per source, fed its own operand bit
    for (genvar i = 0; i < NUM_IRQ; i++) begin : g_irq
        irq_cell u_irq_cell (
            .clk          (clk),
            .rst_n        (rst_n),
            .stall_n_i    (stall_n_i),
            .irq_i        (irq_i[i]),
            .global_ie_i  (mstatus_mie),
            .csr_op_i     (csr_op),
            .sel_mie_i    (sel_mie),
            .sel_mip_i    (sel_mip),
            .wr_bit_mie_i (wr_operand[IRQ_MIP_BIT[i]]),
            .wr_bit_mip_i (wr_operand[IRQ_MIP_BIT[i]]),
            .enable_o     (irq_en[i]),
            .pending_o    (irq_pend[i])
        );
    end

    trap_ctrl u_trap_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_n_i     (stall_n_i),
        .csr_op_i      (csr_op),
        .sel_mstatus_i (sel_mstatus),
        .sel_mtvec_i   (sel_mtvec),
        .sel_mepc_i    (sel_mepc),
        .sel_mcause_i  (sel_mcause),
        .sel_mie_i     (sel_mie),
        .sel_mip_i     (sel_mip),
        .is_ecall_i    (is_ecall),
        .is_mret_i     (is_mret),
        .wr_operand_i  (wr_operand),
        .irq_en_i      (irq_en),
        .irq_pend_i    (irq_pend),
        .pc_i          (pc_i),
        .irq_pc_i      (irq_pc_i),
        .mstatus_mie_o (mstatus_mie),
        .trap_taken_o  (trap_taken_o),
        .csr_rdata_o   (csr_rdata_o),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o)
    );

endmodule

/* trap_ctrl.sv */
`timescale 1ns/10ps

module trap_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall_n_i,
    input  csr_pkg::csr_op_e              csr_op_i,
    input  logic                          sel_mstatus_i,
    input  logic                          sel_mtvec_i,
    input  logic                          sel_mepc_i,
    input  logic                          sel_mcause_i,
    input  logic                          sel_mie_i,
    input  logic                          sel_mip_i,
    input  logic                          is_ecall_i,
    input  logic                          is_mret_i,
    input  logic [csr_pkg::XLEN-1:0]      wr_operand_i,
    input  logic [csr_pkg::NUM_IRQ-1:0]   irq_en_i,
    input  logic [csr_pkg::NUM_IRQ-1:0]   irq_pend_i,
    input  logic [csr_pkg::XLEN-1:0]      pc_i,
    input  logic [csr_pkg::XLEN-1:0]      irq_pc_i,
    output logic                          mstatus_mie_o,
    output logic                          trap_taken_o,
    output logic [csr_pkg::XLEN-1:0]      csr_rdata_o,
    output logic [csr_pkg::XLEN-1:0]      mtvec_o,
    output logic [csr_pkg::XLEN-1:0]      mepc_o
);
    import csr_pkg::*;

    logic [XLEN-1:0]    mstatus_q;
    logic [XLEN-1:0]    mtvec_q;
    logic [XLEN-1:0]    mepc_q;
    logic [XLEN-1:0]    mcause_q;
    logic [XLEN-1:0]    mie_word;
    logic [XLEN-1:0]    mip_word;
    logic [NUM_IRQ-1:0] irq_hit;
    logic [CAUSE_W-1:0] irq_code;
    logic               irq_take;
    logic               do_trap;
    logic               csr_wr;

    function automatic logic [XLEN-1:0] apply_op(
        input csr_op_e         op,
        input logic [XLEN-1:0] old_val,
        input logic [XLEN-1:0] operand
    );
        case (op)
            RW:      apply_op = operand;
            SET:     apply_op = old_val | operand;
            CLR:     apply_op = old_val & ~operand;
            default: apply_op = old_val;
        endcase
    endfunction

    assign irq_hit  = irq_en_i & irq_pend_i;
    assign irq_take = mstatus_q[MSTATUS_MIE_BIT] && (|irq_hit);
    assign do_trap  = irq_take || is_ecall_i;

    // csr writes are dropped in a trap cycle
    assign csr_wr = stall_n_i && !do_trap && (csr_op_i != NONE);

    // external first, then software, then timer
    always_comb begin
        irq_code = '0;
        if (irq_hit[IRQ_EXT]) begin
            irq_code = IRQ_CAUSE[IRQ_EXT];
        end else if (irq_hit[IRQ_SW]) begin
            irq_code = IRQ_CAUSE[IRQ_SW];
        end else if (irq_hit[IRQ_TIMER]) begin
            irq_code = IRQ_CAUSE[IRQ_TIMER];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q <= MSTATUS_RESET;
        end else if (stall_n_i) begin
            if (do_trap) begin
                mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
                mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
            end else if (is_mret_i) begin
                mstatus_q[MSTATUS_MIE_BIT]  <= mstatus_q[MSTATUS_MPIE_BIT];
                mstatus_q[MSTATUS_MPIE_BIT] <= 1'b1;
            end else if (csr_wr && sel_mstatus_i) begin
                mstatus_q <= apply_op(csr_op_i, mstatus_q, wr_operand_i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q <= '0;
        end else if (csr_wr && sel_mtvec_i) begin
            mtvec_q <= apply_op(csr_op_i, mtvec_q, wr_operand_i) & ADDR_ALIGN_MASK;
        end
    end

    // interrupt beats ecall for the saved pc
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (stall_n_i) begin
            if (irq_take) begin
                mepc_q <= irq_pc_i & ADDR_ALIGN_MASK;
            end else if (is_ecall_i) begin
                mepc_q <= pc_i & ADDR_ALIGN_MASK;
            end else if (csr_wr && sel_mepc_i) begin
                mepc_q <= apply_op(csr_op_i, mepc_q, wr_operand_i) & ADDR_ALIGN_MASK;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause_q <= '0;
        end else if (stall_n_i) begin
            if (irq_take) begin
                mcause_q <= {1'b1, {(XLEN-1-CAUSE_W){1'b0}}, irq_code};
            end else if (is_ecall_i) begin
                mcause_q <= {{(XLEN-CAUSE_W){1'b0}}, CAUSE_ECALL_M};
            end else if (csr_wr && sel_mcause_i) begin
                mcause_q <= apply_op(csr_op_i, mcause_q, wr_operand_i);
            end
        end
    end

    // place cell bits at their mie/mip positions
    always_comb begin
        mie_word = '0;
        mip_word = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            mie_word[IRQ_MIP_BIT[i]] = irq_en_i[i];
            mip_word[IRQ_MIP_BIT[i]] = irq_pend_i[i];
        end
    end

    assign csr_rdata_o = ({XLEN{sel_mstatus_i}} & mstatus_q)
                       | ({XLEN{sel_mtvec_i}}   & mtvec_q)
                       | ({XLEN{sel_mepc_i}}    & mepc_q)
                       | ({XLEN{sel_mcause_i}}  & mcause_q)
                       | ({XLEN{sel_mie_i}}     & mie_word)
                       | ({XLEN{sel_mip_i}}     & mip_word);

    assign trap_taken_o  = do_trap;
    assign mstatus_mie_o = mstatus_q[MSTATUS_MIE_BIT];
    assign mtvec_o       = mtvec_q;
    assign mepc_o        = mepc_q;

    assert property (@(posedge clk) disable iff (!rst_n) mepc_q[1:0] == 2'b00)
        else $error("trap_ctrl: mepc low bits not zero");

endmodule

/* irq_cell.sv */
`timescale 1ns/10ps

module irq_cell (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall_n_i,
    input  logic             irq_i,
    input  logic             global_ie_i,
    input  csr_pkg::csr_op_e csr_op_i,
    input  logic             sel_mie_i,
    input  logic             sel_mip_i,
    input  logic             wr_bit_mie_i,
    input  logic             wr_bit_mip_i,
    output logic             enable_o,
    output logic             pending_o
);
    import csr_pkg::*;

    logic enable_q;
    logic pending_q;
    logic enable_nxt;
    logic pending_nxt;
    logic mie_wr;
    logic mip_wr;

    assign mie_wr = sel_mie_i && stall_n_i && (csr_op_i != NONE);
    assign mip_wr = sel_mip_i && stall_n_i && (csr_op_i != NONE);

    // write rule on this source's single bit
    always_comb begin
        enable_nxt  = enable_q;
        pending_nxt = pending_q;
        case (csr_op_i)
            RW: begin
                enable_nxt  = wr_bit_mie_i;
                pending_nxt = wr_bit_mip_i;
            end
            SET: begin
                enable_nxt  = enable_q | wr_bit_mie_i;
                pending_nxt = pending_q | wr_bit_mip_i;
            end
            CLR: begin
                enable_nxt  = enable_q & ~wr_bit_mie_i;
                pending_nxt = pending_q & ~wr_bit_mip_i;
            end
            default: enable_nxt = enable_q;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b0;
        end else if (mie_wr) begin
            enable_q <= enable_nxt;
        end
    end

    // pending tracks the line every cycle, a mip write wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
        end else if (mip_wr) begin
            pending_q <= pending_nxt;
        end else if (irq_i && enable_q && global_ie_i) begin
            pending_q <= 1'b1;
        end else if (!irq_i) begin
            pending_q <= 1'b0;
        end
    end

    assign enable_o  = enable_q;
    assign pending_o = pending_q;

    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pending_q) |-> ($past(irq_i) || $past(mip_wr)))
        else $error("irq_cell: pending rose with line low and no mip write");

endmodule

/* csr_decode.sv */
`timescale 1ns/10ps

module csr_decode (
    input  csr_pkg::rv_instr_u          instr_i,
    input  logic [csr_pkg::XLEN-1:0]    rs1_data_i,
    output csr_pkg::csr_op_e            csr_op_o,
    output logic                        sel_mstatus_o,
    output logic                        sel_mie_o,
    output logic                        sel_mtvec_o,
    output logic                        sel_mepc_o,
    output logic                        sel_mcause_o,
    output logic                        sel_mip_o,
    output logic                        is_ecall_o,
    output logic                        is_mret_o,
    output logic [csr_pkg::XLEN-1:0]    wr_operand_o
);
    import csr_pkg::*;

    logic is_system;
    logic is_priv;
    logic csr_access;

    assign is_system = (instr_i.csr.opcode == OPC_SYSTEM);

    // op kind from funct3, bit 2 only picks the immediate form
    always_comb begin
        csr_op_o = NONE;
        if (is_system) begin
            case (instr_i.csr.funct3)
                3'b001, 3'b101: csr_op_o = RW;
                3'b010, 3'b110: csr_op_o = SET;
                3'b011, 3'b111: csr_op_o = CLR;
                default:        csr_op_o = NONE;
            endcase
        end
    end

    assign csr_access = (csr_op_o != NONE);

    // selects double as read enables
    assign sel_mstatus_o = csr_access && (instr_i.csr.addr == CSR_MSTATUS);
    assign sel_mie_o     = csr_access && (instr_i.csr.addr == CSR_MIE);
    assign sel_mtvec_o   = csr_access && (instr_i.csr.addr == CSR_MTVEC);
    assign sel_mepc_o    = csr_access && (instr_i.csr.addr == CSR_MEPC);
    assign sel_mcause_o  = csr_access && (instr_i.csr.addr == CSR_MCAUSE);
    assign sel_mip_o     = csr_access && (instr_i.csr.addr == CSR_MIP);

    // privileged form: funct3, rs1 and rd all zero
    assign is_priv = is_system
                  && (instr_i.priv.funct3 == 3'b000)
                  && (instr_i.priv.rs1 == 5'd0)
                  && (instr_i.priv.rd == 5'd0);

    assign is_ecall_o = is_priv && (instr_i.priv.funct12 == FUNCT12_ECALL);
    assign is_mret_o  = is_priv && (instr_i.priv.funct12 == FUNCT12_MRET);

    // uimm sits in the rs1 field, zero extended
    assign wr_operand_o = instr_i.csr.funct3[2] ? {{(XLEN-5){1'b0}}, instr_i.csr.rs1}
                                                : rs1_data_i;

    always_comb begin
        assert ($onehot0({is_ecall_o, is_mret_o, csr_access}))
            else $error("csr_decode: ecall, mret and csr op raised together");
    end

endmodule

/* csr_pkg.sv */
package csr_pkg;

    localparam int XLEN    = 64;
    localparam int NUM_IRQ = 3;

    // source indices, also the bit position in the source vectors
    localparam int IRQ_SW    = 0;
    localparam int IRQ_TIMER = 1;
    localparam int IRQ_EXT   = 2;

    // mip/mie bit of each source
    localparam int unsigned IRQ_MIP_BIT [NUM_IRQ] = '{3, 7, 11};

    // cause code width and per-source interrupt codes
    localparam int CAUSE_W = 6;
    localparam logic [CAUSE_W-1:0] IRQ_CAUSE [NUM_IRQ] = '{6'd3, 6'd7, 6'd11};
    localparam logic [CAUSE_W-1:0] CAUSE_ECALL_M = 6'd11;

    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MIE     = 12'h304;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;
    localparam logic [11:0] CSR_MIP     = 12'h344;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    // MPP = 3, machine mode only
    localparam logic [XLEN-1:0] MSTATUS_RESET   = 64'h0000_0000_0000_1800;
    localparam logic [XLEN-1:0] ADDR_ALIGN_MASK = {{(XLEN-2){1'b1}}, 2'b00};

    localparam logic [6:0]  OPC_SYSTEM    = 7'b1110011;
    localparam logic [11:0] FUNCT12_ECALL = 12'h000;
    localparam logic [11:0] FUNCT12_MRET  = 12'h302;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        RW   = 2'd1,
        SET  = 2'd2,
        CLR  = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic [11:0] addr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } csr_fmt_t;

    typedef struct packed {
        logic [11:0] funct12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } priv_fmt_t;

    typedef union packed {
        csr_fmt_t  csr;
        priv_fmt_t priv;
    } rv_instr_u;

endpackage
